// File: hdl/mipsDefines.svh
// ==================================================
// MIPS core sizing macros
// widths and counts shared by the RTL and testbench
// ==================================================

`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath and instruction width
`define MIPS_DATA_W   32
// register file addressing
`define MIPS_REG_AW   5
`define MIPS_REG_NUM  32
// data memory word address, alu result bits 8:2
`define MIPS_DMEM_AW  7
// jal destination, $ra
`define MIPS_LINK_REG 31

`endif

// File: hdl/mipsPkg.sv
// ==================================================
// MIPS core types
// instruction encodings and control select enums
// ==================================================

package mipsPkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        rType = 6'b000000,  // funct decides
        opJ   = 6'b000010,
        opJal = 6'b000011,
        opBeq = 6'b000100,
        opLw  = 6'b100011,
        opSw  = 6'b101011
    } opcodeT;

    // funct field for r-type, instr[5:0]
    typedef enum logic [5:0] {
        fnJr  = 6'b001000,
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } functT;

    // alu operation, driven straight from the decoder
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4   // signed compare
    } aluOpT;

    // destination register select
    typedef enum logic [1:0] {
        dstRt   = 2'd0,
        dstRd   = 2'd1,
        dstLink = 2'd2  // $ra for jal
    } regDstT;

    // write-back source
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbMem  = 2'd1,
        wbLink = 2'd2   // pc + 4
    } wbSelT;

    // next pc source
    typedef enum logic [1:0] {
        pcSeq    = 2'd0,
        pcBranch = 2'd1,  // beq, taken on zero
        pcJump   = 2'd2,
        pcReg    = 2'd3   // jr
    } pcSelT;

endpackage

// File: hdl/ctrlIf.sv
// ==================================================
// decoded control bundle
// one driver (decoder), read by datapath and pc logic
// ==================================================

interface ctrlIf;

    mipsPkg::regDstT regDst;     // write register select
    mipsPkg::wbSelT  wbSel;      // write-back source
    logic            regWrite;   // register file write
    logic            memWrite;   // data memory write, sw only
    logic            aluSrcImm;  // second operand is the immediate
    mipsPkg::aluOpT  aluOp;
    mipsPkg::pcSelT  pcSel;

    // decoder side, owns every signal
    modport decoder (
        output regDst, wbSel, regWrite, memWrite, aluSrcImm, aluOp, pcSel
    );

    // execute unit and top level muxes
    modport datapath (
        input aluOp, aluSrcImm, regDst, wbSel, regWrite, memWrite
    );

    // next pc selection
    modport pcCtl (
        input pcSel
    );

endinterface

// File: hdl/mainDecoder.sv
// ==================================================
// main decoder
// opcode and funct to the full control bundle
// ==================================================

`include "mipsDefines.svh"

module mainDecoder (
    input  logic [`MIPS_DATA_W-1:0] instr,
    ctrlIf.decoder                  ctrl
);

    mipsPkg::opcodeT opcode;
    mipsPkg::functT  funct;

    assign opcode = mipsPkg::opcodeT'(instr[31:26]);
    assign funct  = mipsPkg::functT'(instr[5:0]);

    // ==================================================
    // decode
    // ==================================================
    always_comb begin
        // no-op bundle, also what unknown encodings get
        ctrl.regDst    = mipsPkg::dstRt;
        ctrl.wbSel     = mipsPkg::wbAlu;
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.aluSrcImm = 1'b0;
        ctrl.aluOp     = mipsPkg::aluAdd;
        ctrl.pcSel     = mipsPkg::pcSeq;

        case (opcode)
            mipsPkg::rType: begin
                case (funct)
                    mipsPkg::fnJr: ctrl.pcSel = mipsPkg::pcReg;  // no write
                    mipsPkg::fnAdd, mipsPkg::fnSub, mipsPkg::fnAnd,
                    mipsPkg::fnOr, mipsPkg::fnSlt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst   = mipsPkg::dstRd;
                        case (funct)
                            mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
                            mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
                            mipsPkg::fnOr:  ctrl.aluOp = mipsPkg::aluOr;
                            mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
                            default:        ctrl.aluOp = mipsPkg::aluAdd;
                        endcase
                    end
                    default: ;  // unknown funct stays a no-op
                endcase
            end
            mipsPkg::opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;          // base + offset
                ctrl.wbSel     = mipsPkg::wbMem;
            end
            mipsPkg::opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.aluOp = mipsPkg::aluSub;   // zero flag = equal
                ctrl.pcSel = mipsPkg::pcBranch;
            end
            mipsPkg::opJ: ctrl.pcSel = mipsPkg::pcJump;
            mipsPkg::opJal: begin
                ctrl.pcSel    = mipsPkg::pcJump;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = mipsPkg::dstLink;  // $ra
                ctrl.wbSel    = mipsPkg::wbLink;   // return address
            end
            default: ;  // unknown opcode, pc + 4 only
        endcase
    end

endmodule

// File: hdl/regFile.sv
// ==================================================
// register file
// 2 read ports, 1 write port, $zero hard-wired
// ==================================================

`include "mipsDefines.svh"

module regFile (
    input  logic                    Clk,
    input  logic                    reset,
    input  logic                    writeEn,
    input  logic [`MIPS_REG_AW-1:0] writeAddr,
    input  logic [`MIPS_DATA_W-1:0] writeData,
    input  logic [`MIPS_REG_AW-1:0] readAddrA,
    input  logic [`MIPS_REG_AW-1:0] readAddrB,
    output logic [`MIPS_DATA_W-1:0] readDataA,
    output logic [`MIPS_DATA_W-1:0] readDataB
);

    // entry 0 not stored
    logic [`MIPS_DATA_W-1:0] regs [1:`MIPS_REG_NUM-1];
    logic                    writeHit;

    // writes to $zero are dropped here
    assign writeHit = writeEn && (writeAddr != '0);

    // ==================================================
    // write port
    // ==================================================
    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (writeHit) begin
            regs[writeAddr] <= writeData;  // commits with the pc update
        end
    end

    // ==================================================
    // read ports
    // ==================================================
    // combinational, no bypass needed in a single-cycle core
    always_comb begin
        if (readAddrA == '0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readAddrA];
        end
    end

    always_comb begin
        if (readAddrB == '0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

// File: hdl/executeUnit.sv
// ==================================================
// execute unit
// operand select, sign extension, alu, zero flag
// ==================================================

`include "mipsDefines.svh"

module executeUnit (
    ctrlIf.datapath                 ctrl,
    input  logic [`MIPS_DATA_W-1:0] instr,
    input  logic [`MIPS_DATA_W-1:0] rsData,
    input  logic [`MIPS_DATA_W-1:0] rtData,
    output logic [`MIPS_DATA_W-1:0] aluResult,
    output logic                    zero
);

    logic [`MIPS_DATA_W-1:0] immExt;    // sign-extended imm16
    logic [`MIPS_DATA_W-1:0] operandB;
    logic [`MIPS_DATA_W-1:0] sum;
    logic [`MIPS_DATA_W-1:0] diff;
    logic                    lessThan;  // signed rs < b

    assign immExt   = {{(`MIPS_DATA_W-16){instr[15]}}, instr[15:0]};
    assign operandB = ctrl.aluSrcImm ? immExt : rtData;  // lw/sw use imm

    assign sum      = rsData + operandB;
    assign diff     = rsData - operandB;
    assign lessThan = $signed(rsData) < $signed(operandB);

    // ==================================================
    // alu
    // ==================================================
    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::aluAdd: aluResult = sum;
            mipsPkg::aluSub: aluResult = diff;
            mipsPkg::aluAnd: aluResult = rsData & operandB;
            mipsPkg::aluOr:  aluResult = rsData | operandB;
            mipsPkg::aluSlt: begin
                // 1 or 0, zero-extended
                aluResult = {{(`MIPS_DATA_W-1){1'b0}}, lessThan};
            end
            default:         aluResult = sum;
        endcase
    end

    // equality only meaningful for beq, held low otherwise
    assign zero = (ctrl.aluOp == mipsPkg::aluSub) && (diff == '0);

endmodule

// File: hdl/pcUnit.sv
// ==================================================
// program counter
// pc register and next-pc select
// ==================================================

`include "mipsDefines.svh"

module pcUnit (
    input  logic                    Clk,
    input  logic                    reset,
    ctrlIf.pcCtl                    ctrl,
    input  logic [`MIPS_DATA_W-1:0] instr,
    input  logic                    zero,
    input  logic [`MIPS_DATA_W-1:0] rsData,
    output logic [`MIPS_DATA_W-1:0] pc,
    output logic [`MIPS_DATA_W-1:0] pcPlus4,
    output logic [`MIPS_DATA_W-1:0] nextPc
);

    logic [`MIPS_DATA_W-1:0] branchTarget;
    logic [`MIPS_DATA_W-1:0] jumpTarget;

    assign pcPlus4 = pc + `MIPS_DATA_W'(4);  // also the jal link value

    // imm16 sign-extended, word offset
    assign branchTarget = pcPlus4 + {{(`MIPS_DATA_W-18){instr[15]}}, instr[15:0], 2'b00};
    // pseudo-direct, top nibble from pc + 4
    assign jumpTarget   = {pcPlus4[`MIPS_DATA_W-1 -: 4], instr[25:0], 2'b00};

    // ==================================================
    // next pc
    // ==================================================
    always_comb begin
        case (ctrl.pcSel)
            mipsPkg::pcBranch: nextPc = zero ? branchTarget : pcPlus4;  // beq taken?
            mipsPkg::pcJump:   nextPc = jumpTarget;
            mipsPkg::pcReg:    nextPc = rsData;   // jr
            default:           nextPc = pcPlus4;
        endcase
    end

    // one instruction per edge
    always_ff @(posedge Clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;  // fetch starts at address 0
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: hdl/singleCycleMips.sv
// ==================================================
// single-cycle MIPS core, top level
// decoder, register file, execute, pc and wb muxes
// ==================================================

`include "mipsDefines.svh"

module singleCycleMips (
    input  logic                     Clk,
    input  logic                     reset,
    // instruction memory
    input  logic [`MIPS_DATA_W-1:0]  instr,
    output logic [`MIPS_DATA_W-1:0]  instrAddr,
    // observation of the write-back value
    output logic [`MIPS_DATA_W-1:0]  rfWriteData,
    // data memory
    input  logic [`MIPS_DATA_W-1:0]  memReadData,
    output logic [`MIPS_DMEM_AW-1:0] memAddr,
    output logic [`MIPS_DATA_W-1:0]  memWriteData,
    output logic                     memWriteN
);

    logic [`MIPS_DATA_W-1:0] rsData;
    logic [`MIPS_DATA_W-1:0] rtData;
    logic [`MIPS_DATA_W-1:0] aluResult;
    logic                    zero;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] pcPlus4;
    logic [`MIPS_REG_AW-1:0] writeReg;
    logic [`MIPS_DATA_W-1:0] writeBack;

    ctrlIf ctrlBus ();  // decoded control, one driver

    // ==================================================
    // instances
    // ==================================================
    mainDecoder decoderInst (
        .instr (instr),
        .ctrl  (ctrlBus.decoder)
    );

    regFile regFileInst (
        .Clk       (Clk),
        .reset     (reset),
        .writeEn   (ctrlBus.regWrite),
        .writeAddr (writeReg),
        .writeData (writeBack),
        .readAddrA (instr[25:21]),  // rs
        .readAddrB (instr[20:16]),  // rt
        .readDataA (rsData),
        .readDataB (rtData)
    );

    executeUnit executeInst (
        .ctrl      (ctrlBus.datapath),
        .instr     (instr),
        .rsData    (rsData),
        .rtData    (rtData),
        .aluResult (aluResult),
        .zero      (zero)
    );

    pcUnit pcInst (
        .Clk     (Clk),
        .reset   (reset),
        .ctrl    (ctrlBus.pcCtl),
        .instr   (instr),
        .zero    (zero),
        .rsData  (rsData),
        .pc      (pc),
        .pcPlus4 (pcPlus4),
        .nextPc  ()
    );

    // ==================================================
    // write-back muxes
    // ==================================================
    always_comb begin
        case (ctrlBus.regDst)
            mipsPkg::dstRd:   writeReg = instr[15:11];
            mipsPkg::dstLink: writeReg = `MIPS_REG_AW'(`MIPS_LINK_REG);  // $ra
            default:          writeReg = instr[20:16];                   // rt
        endcase
    end

    always_comb begin
        case (ctrlBus.wbSel)
            mipsPkg::wbMem:  writeBack = memReadData;  // lw
            mipsPkg::wbLink: writeBack = pcPlus4;      // jal return address
            default:         writeBack = aluResult;
        endcase
    end

    // ports
    assign instrAddr    = pc;
    assign rfWriteData  = writeBack;
    assign memAddr      = aluResult[`MIPS_DMEM_AW+1:2];  // word address
    assign memWriteData = rtData;
    assign memWriteN    = ~ctrlBus.memWrite;               // active-low strobe

endmodule

// File: verif/mipsCore_assert.sv
// ==================================================
// MIPS core assertions
// bound to the top level, memory strobe and fetch pc
// ==================================================

`include "mipsDefines.svh"

module mipsCoreAssert (
    input logic                    Clk,
    input logic                    reset,
    input logic [`MIPS_DATA_W-1:0] instr,
    input logic [`MIPS_DATA_W-1:0] instrAddr,
    input logic                    memWriteN
);

    // write strobe only for sw
    swOnlyStrobe: assert property (@(posedge Clk) disable iff (!reset)
        !memWriteN |-> (instr[31:26] == mipsPkg::opSw))
        else $error("memWriteN low while the opcode is not sw");

    pcAligned: assert property (@(posedge Clk) disable iff (!reset)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr is not word aligned");

    // first fetch after reset comes from address 0
    pcStartsAtZero: assert property (@(posedge Clk)
        $rose(reset) |-> (instrAddr == '0))
        else $error("instrAddr not 0 in the first cycle after reset");

    pcKnown: assert property (@(posedge Clk) disable iff (!reset)
        !$isunknown(instrAddr))
        else $error("instrAddr has unknown bits");

endmodule

bind singleCycleMips mipsCoreAssert coreAssertInst (
    .Clk       (Clk),
    .reset     (reset),
    .instr     (instr),
    .instrAddr (instrAddr),
    .memWriteN (memWriteN)
);

// File: verif/mipsChecker.sv
// ==================================================
// MIPS checker
// architectural model of the core, compared each cycle
// ==================================================

`include "mipsDefines.svh"

module mipsChecker (
    input  logic                     Clk,
    input  logic                     reset,
    input  logic [`MIPS_DATA_W-1:0]  instrAddr,
    input  logic [`MIPS_DATA_W-1:0]  rfWriteData,
    input  logic [`MIPS_DMEM_AW-1:0] memAddr,
    input  logic [`MIPS_DATA_W-1:0]  memWriteData,
    input  logic                     memWriteN,
    input  logic [`MIPS_DATA_W-1:0]  prog [256],
    output int                       errCount,
    output int                       stepCount
);

    logic [31:0] mRegs [32];   // model register file
    logic [31:0] mMem [128];   // model data memory
    logic [31:0] mPc;
    logic        skipFirst;    // word 0 commits before the first compare
    // expected effects of the current instruction
    logic        expWe;
    logic [4:0]  expWr;
    logic [31:0] expWd;
    logic        expMw;
    logic [6:0]  expMa;
    logic [31:0] expMd;
    logic [31:0] expNext;

    initial begin
        errCount  = 0;
        stepCount = 0;
    end

    // same fill rule as the testbench memory
    function automatic logic [31:0] fillWord(input int addr);
        return 32'h9e37_79b9 * 32'(addr + 1);
    endfunction

    // ==================================================
    // reference model, one instruction
    // ==================================================
    function automatic void refExecute(input logic [31:0] ins);
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] imm;
        logic [31:0] pc4;
        logic [31:0] addr;
        rsV  = mRegs[ins[25:21]];
        rtV  = mRegs[ins[20:16]];
        imm  = {{16{ins[15]}}, ins[15:0]};
        pc4  = mPc + 32'd4;
        addr = rsV + imm;
        expWe = 1'b0;
        expWr = '0;
        expWd = '0;
        expMw = 1'b0;
        expMa = '0;
        expMd = '0;
        expNext = pc4;   // also the no-op case
        case (ins[31:26])
            mipsPkg::rType: begin
                expWr = ins[15:11];
                case (ins[5:0])
                    mipsPkg::fnAdd: begin expWe = 1'b1; expWd = rsV + rtV; end
                    mipsPkg::fnSub: begin expWe = 1'b1; expWd = rsV - rtV; end
                    mipsPkg::fnAnd: begin expWe = 1'b1; expWd = rsV & rtV; end
                    mipsPkg::fnOr:  begin expWe = 1'b1; expWd = rsV | rtV; end
                    mipsPkg::fnSlt: begin
                        expWe = 1'b1;
                        expWd = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
                    end
                    mipsPkg::fnJr: expNext = rsV;
                    default: ;
                endcase
            end
            mipsPkg::opLw: begin
                expWe = 1'b1;
                expWr = ins[20:16];
                expWd = mMem[addr[8:2]];
            end
            mipsPkg::opSw: begin
                expMw = 1'b1;
                expMa = addr[8:2];
                expMd = rtV;
            end
            mipsPkg::opBeq: begin
                if (rsV == rtV) expNext = pc4 + {imm[29:0], 2'b00};
            end
            mipsPkg::opJ: expNext = {pc4[31:28], ins[25:0], 2'b00};
            mipsPkg::opJal: begin
                expNext = {pc4[31:28], ins[25:0], 2'b00};
                expWe   = 1'b1;
                expWr   = 5'd31;   // $ra
                expWd   = pc4;
            end
            default: ;
        endcase
    endfunction

    function automatic void commitModel();
        if (expWe && expWr != 5'd0) mRegs[expWr] = expWd;  // $zero stays 0
        if (expMw) mMem[expMa] = expMd;
        mPc = expNext;
    endfunction

    task automatic compareWord(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
            errCount++;
        end
    endtask

    // ==================================================
    // compare on the falling edge
    // ==================================================
    always @(negedge Clk) begin
        if (!reset) begin
            mPc       = '0;
            skipFirst = 1'b1;
            for (int i = 0; i < 32; i++) mRegs[i] = '0;
            for (int i = 0; i < 128; i++) mMem[i] = fillWord(i);
        end else begin
            if (skipFirst) begin
                skipFirst = 1'b0;
                refExecute(prog[0]);   // word 0 ran on the release edge
                commitModel();
            end
            compareWord("instrAddr", instrAddr, mPc);
            refExecute(prog[mPc[9:2]]);
            if (expWe) compareWord("rfWriteData", rfWriteData, expWd);
            if (memWriteN !== !expMw) begin
                $display("ERROR @%0t: memWriteN is %b, expected %b", $time, memWriteN, !expMw);
                errCount++;
            end
            if (expMw) begin
                compareWord("memAddr", 32'(memAddr), 32'(expMa));
                compareWord("memWriteData", memWriteData, expMd);
            end
            commitModel();
            stepCount++;
        end
    end

endmodule

// File: verif/mipsTb.sv
// ==================================================
// MIPS core testbench
// rom, data memory, program build, watchdog, report
// ==================================================

`include "mipsDefines.svh"

module mipsTb;

    logic                     Clk = 1'b0;
    logic                     reset;
    logic [`MIPS_DATA_W-1:0]  instr;
    logic [`MIPS_DATA_W-1:0]  instrAddr;
    logic [`MIPS_DATA_W-1:0]  rfWriteData;
    logic [`MIPS_DATA_W-1:0]  memReadData;
    logic [`MIPS_DMEM_AW-1:0] memAddr;
    logic [`MIPS_DATA_W-1:0]  memWriteData;
    logic                     memWriteN;

    logic [31:0] rom [256];    // instruction rom, word indexed
    logic [31:0] dmem [128];
    int          progLen;
    logic [31:0] endAddr;      // final self-jump
    int          errCount;
    int          stepCount;
    integer      seed = 32'h2c68_c76f;

    always #4 Clk = ~Clk;      // period 8

    singleCycleMips singleCycleMips_inst (
        .Clk          (Clk),
        .reset        (reset),
        .instr        (instr),
        .instrAddr    (instrAddr),
        .rfWriteData  (rfWriteData),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWriteN    (memWriteN)
    );

    mipsChecker checkerInst (
        .Clk          (Clk),
        .reset        (reset),
        .instrAddr    (instrAddr),
        .rfWriteData  (rfWriteData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWriteN    (memWriteN),
        .prog         (rom),
        .errCount     (errCount),
        .stepCount    (stepCount)
    );

    // ==================================================
    // memories
    // ==================================================
    assign instr       = rom[instrAddr[9:2]];
    assign memReadData = dmem[memAddr];

    function automatic logic [31:0] fillWord(input int addr);
        return 32'h9e37_79b9 * 32'(addr + 1);  // mixes every address bit
    endfunction

    always @(posedge Clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 128; i++) dmem[i] <= fillWord(i);
        end else if (!memWriteN) begin
            dmem[memAddr] <= memWriteData;
        end
    end

    // instruction encoding
    function automatic logic [31:0] rTypeWord(input int rs, input int rt, input int rd,
                                              input int fn);
        return {6'b0, 5'(rs), 5'(rt), 5'(rd), 5'b0, 6'(fn)};
    endfunction

    function automatic logic [31:0] immWord(input int op, input int rs, input int rt,
                                            input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] jumpWord(input int op, input int idx);
        return {6'(op), 26'(idx)};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    // ==================================================
    // program
    // ==================================================
    task automatic buildProgram();
        int kind;
        int rs;
        int rt;
        int rd;
        int sub;
        for (int i = 0; i < 256; i++) rom[i] = '0;
        progLen = 0;
        emit(jumpWord('h3f, 0));                          // unknown opcode
        emit(immWord(int'(mipsPkg::opLw), 0, 1, 0));      // negative
        emit(immWord(int'(mipsPkg::opLw), 0, 2, 4));      // positive
        emit(immWord(int'(mipsPkg::opLw), 0, 3, 8));      // negative
        emit(rTypeWord(1, 2, 4, int'(mipsPkg::fnAdd)));
        emit(rTypeWord(1, 2, 5, int'(mipsPkg::fnSub)));
        emit(rTypeWord(1, 2, 6, int'(mipsPkg::fnAnd)));
        emit(rTypeWord(1, 3, 7, int'(mipsPkg::fnOr)));
        emit(rTypeWord(1, 2, 4, int'(mipsPkg::fnSlt)));
        emit(rTypeWord(2, 1, 4, int'(mipsPkg::fnSlt)));
        emit(rTypeWord(1, 3, 6, int'(mipsPkg::fnSlt)));   // both negative
        emit(rTypeWord(1, 2, 5, int'(mipsPkg::fnSub)));
        emit(immWord(int'(mipsPkg::opSw), 0, 5, 12));
        emit(immWord(int'(mipsPkg::opLw), 0, 6, 12));     // reads back the store
        emit(rTypeWord(1, 2, 0, int'(mipsPkg::fnAdd)));   // to $zero
        emit(rTypeWord(0, 0, 7, int'(mipsPkg::fnAdd)));
        emit(immWord(int'(mipsPkg::opBeq), 1, 1, 1));     // taken
        emit(rTypeWord(1, 1, 7, int'(mipsPkg::fnAdd)));
        emit(immWord(int'(mipsPkg::opBeq), 1, 2, 1));     // not taken
        emit(rTypeWord(2, 2, 7, int'(mipsPkg::fnAdd)));
        sub = progLen + 2;
        emit(jumpWord(int'(mipsPkg::opJal), sub));
        emit(jumpWord(int'(mipsPkg::opJ), sub + 2));
        emit(rTypeWord(1, 2, 7, int'(mipsPkg::fnAdd)));   // subroutine
        emit(rTypeWord(31, 0, 0, int'(mipsPkg::fnJr)));
        emit(rTypeWord(1, 2, 3, 'h3f));                   // unknown funct
        emit(jumpWord('h3e, 0));                          // unknown opcode
        for (int n = 0; n < 200; n++) begin
            kind = int'($unsigned($random(seed)) % 7);
            rs   = 1 + int'($unsigned($random(seed)) % 7);
            rt   = 1 + int'($unsigned($random(seed)) % 7);
            rd   = 1 + int'($unsigned($random(seed)) % 7);
            case (kind)
                0: emit(rTypeWord(rs, rt, rd, int'(mipsPkg::fnAdd)));
                1: emit(rTypeWord(rs, rt, rd, int'(mipsPkg::fnSub)));
                2: emit(rTypeWord(rs, rt, rd, int'(mipsPkg::fnAnd)));
                3: emit(rTypeWord(rs, rt, rd, int'(mipsPkg::fnOr)));
                4: emit(rTypeWord(rs, rt, rd, int'(mipsPkg::fnSlt)));
                5: emit(immWord(int'(mipsPkg::opLw), 0, rt,
                                4 * int'($unsigned($random(seed)) % 128)));
                default: emit(immWord(int'(mipsPkg::opSw), 0, rt,
                                      4 * int'($unsigned($random(seed)) % 128)));
            endcase
        end
        endAddr = 32'(progLen * 4);
        emit(jumpWord(int'(mipsPkg::opJ), progLen));      // self-jump
    endtask

    // ==================================================
    // run and report
    // ==================================================
    initial begin
        reset = 1'b0;
        buildProgram();
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        reset <= 1'b1;
        wait (instrAddr == endAddr);
        repeat (2) @(negedge Clk);
        $display("checked %0d instructions, %0d errors", stepCount, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog, twice the straight-line program time
    initial begin
        @(posedge reset);
        #(progLen * 8 * 2);
        $display("run timed out, the final self-jump was not reached");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/ctrlIf.sv
hdl/mainDecoder.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/pcUnit.sv
hdl/singleCycleMips.sv
verif/mipsCore_assert.sv
verif/mipsChecker.sv
verif/mipsTb.sv

// File: run.sh
#!/bin/bash
# build with Verilator, run, and decide the result from the log
set -o pipefail

verilator --binary --timing --assert -f verilog.f --top-module mipsTb \
    && ./obj_dir/VmipsTb 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "Finished with errors" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
